//--- Makefile
VERILATOR = verilator
TOP = btb_tb
FLIST = flist.f
BUILD_DIR = obj_dir
LOG = sim.log
PASS_MSG = SIMULATION PASSED

COMMON_FLAGS = --timing --timescale 1ns/100ps --top-module $(TOP) -f $(FLIST)
LINT_FLAGS = --lint-only
SIM_FLAGS = --binary --Mdir $(BUILD_DIR)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) $(COMMON_FLAGS)

sim:
	$(VERILATOR) $(SIM_FLAGS) $(COMMON_FLAGS)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- design/btb.sv
`default_nettype none

`include "btb_config.svh"

module btb (
	input logic CLK,
	input logic nRST,

	// arch state
	input btb_pkg::asid_t arch_asid,

	// read req stage
	input logic read_req_valid,
	input btb_pkg::fetch_idx_t read_req_fetch_index,

	// read resp stage
	input btb_pkg::pc38_t read_resp_pc38,

	output logic read_resp_hit,
	output btb_pkg::btb_way_idx_t read_resp_hit_way,
	output btb_pkg::fetch_lane_t read_resp_hit_lane,
	output logic read_resp_double_hit,
	output btb_pkg::btb_info_t read_resp_btb_info,

	// update
	input logic update_valid,
	input btb_pkg::pc38_t update_pc38,
	input btb_pkg::btb_info_t update_btb_info,
	input logic update_hit,
	input btb_pkg::btb_way_idx_t update_hit_way
);

	import btb_pkg::*;

	logic resp_valid;
	fetch_idx_t resp_index;

	btb_entry_t [`BTB_WAYS-1:0] array_entries;
	logic [`BTB_WAYS-1:0] array_valids;

	fetch_idx_t update_index;
	btb_way_idx_t victim_way;
	btb_way_idx_t write_way;
	btb_entry_t write_entry;

	// ------------------------------
	// request to response stage
	// ------------------------------

	always_ff @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			resp_valid <= 1'b0;
		end else begin
			resp_valid <= read_req_valid;
		end
	end

	// index only matters for lru touch, which needs resp_valid
	always_ff @(posedge CLK) begin
		resp_index <= read_req_fetch_index;
	end

	// ------------------------------
	// update entry
	// ------------------------------

	assign update_index = update_pc38[`BTB_LANE_W +: `BTB_IDX_W];

	// known way on an update hit, else replace
	assign write_way = update_hit ? update_hit_way : victim_way;

	always_comb begin
		write_entry.tag = btb_hash_tag(update_pc38, arch_asid);
		write_entry.lane = update_pc38[`BTB_LANE_W-1:0];
		write_entry.info = update_btb_info;
	end

	// ------------------------------
	// instances
	// ------------------------------

	btb_array array (
		.CLK(CLK), .nRST(nRST),
		.read_valid(read_req_valid), .read_index(read_req_fetch_index),
		.write_valid(update_valid), .write_index(update_index),
		.write_way(write_way), .write_entry(write_entry),
		.read_entries(array_entries), .read_valids(array_valids)
	);

	btb_tag_match tag_match (
		.entries(array_entries), .valids(array_valids),
		.pc38(read_resp_pc38), .asid(arch_asid), .resp_valid(resp_valid),
		.hit(read_resp_hit), .hit_way(read_resp_hit_way),
		.hit_lane(read_resp_hit_lane), .double_hit(read_resp_double_hit),
		.btb_info(read_resp_btb_info)
	);

	btb_lru lru (
		.CLK(CLK), .nRST(nRST),
		.touch_valid(read_resp_hit), .touch_index(resp_index),
		.touch_way(read_resp_hit_way),
		.fill_valid(update_valid), .fill_index(update_index), .fill_way(write_way),
		.victim_way(victim_way)
	);

endmodule

`default_nettype wire

//--- design/btb_array.sv
`default_nettype none

`include "btb_config.svh"

module btb_array (
	input logic CLK,
	input logic nRST,

	// read port, data is registered
	input logic read_valid,
	input btb_pkg::fetch_idx_t read_index,

	// write port, one way per cycle
	input logic write_valid,
	input btb_pkg::fetch_idx_t write_index,
	input btb_pkg::btb_way_idx_t write_way,
	input btb_pkg::btb_entry_t write_entry,

	output btb_pkg::btb_entry_t [`BTB_WAYS-1:0] read_entries,
	output logic [`BTB_WAYS-1:0] read_valids
);

	import btb_pkg::*;

	// ------------------------------
	// storage
	// ------------------------------

	btb_entry_t entry_mem [`BTB_SETS][`BTB_WAYS];
	logic [`BTB_WAYS-1:0] valid_q [`BTB_SETS];

	// ------------------------------
	// entry ram
	// ------------------------------

	// same-edge read sees the old entry
	always_ff @(posedge CLK) begin
		if (write_valid) begin
			entry_mem[write_index][write_way] <= write_entry;
		end
		if (read_valid) begin
			for (int w = 0; w < `BTB_WAYS; w++) begin
				read_entries[w] <= entry_mem[read_index][w];
			end
		end
	end

	// ------------------------------
	// valid bits
	// ------------------------------

	always_ff @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			for (int s = 0; s < `BTB_SETS; s++) begin
				valid_q[s] <= '0;
			end
			read_valids <= '0;
		end else begin
			if (write_valid) begin
				valid_q[write_index][write_way] <= 1'b1;
			end
			// outputs hold between reads
			if (read_valid) begin
				read_valids <= valid_q[read_index];
			end
		end
	end

endmodule

`default_nettype wire

//--- design/btb_config.svh
`ifndef BTB_CONFIG_SVH
`define BTB_CONFIG_SVH

// ------------------------------
// geometry
// ------------------------------

// sets per way
`define BTB_SETS 64

// two-way set associative
`define BTB_WAYS 2

// lanes per fetch block, one lane per 2-byte parcel
`define BTB_LANES 8

// ------------------------------
// field widths
// ------------------------------

`define BTB_ASID_W 9

// hashed tag, see btb_hash_tag in the package
`define BTB_TAG_W 10

// derived index widths
`define BTB_IDX_W $clog2(`BTB_SETS)
`define BTB_LANE_W $clog2(`BTB_LANES)
`define BTB_WAY_W $clog2(`BTB_WAYS)

`endif

//--- design/btb_lru.sv
`default_nettype none

`include "btb_config.svh"

module btb_lru (
	input logic CLK,
	input logic nRST,

	// read hit from the response stage
	input logic touch_valid,
	input btb_pkg::fetch_idx_t touch_index,
	input btb_pkg::btb_way_idx_t touch_way,

	// way written by an update
	input logic fill_valid,
	input btb_pkg::fetch_idx_t fill_index,
	input btb_pkg::btb_way_idx_t fill_way,

	output btb_pkg::btb_way_idx_t victim_way
);

	import btb_pkg::*;

	// one bit per set, names the least recent way
	btb_way_idx_t lru_way [`BTB_SETS];

	// ------------------------------
	// victim
	// ------------------------------

	assign victim_way = lru_way[fill_index];

	// ------------------------------
	// recency update
	// ------------------------------

	// with two ways the other one becomes least recent
	always_ff @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			for (int s = 0; s < `BTB_SETS; s++) begin
				lru_way[s] <= '0;
			end
		end else begin
			if (touch_valid) begin
				lru_way[touch_index] <= ~touch_way;
			end
			// fill last so it wins on the same set
			if (fill_valid) begin
				lru_way[fill_index] <= ~fill_way;
			end
		end
	end

endmodule

`default_nettype wire

//--- design/btb_pkg.sv
`default_nettype none

`include "btb_config.svh"

package btb_pkg;

	// ------------------------------
	// plain vector types
	// ------------------------------

	typedef logic [`BTB_ASID_W-1:0] asid_t;

	// pc in 2-byte units: lane [2:0], set [8:3], tag source [37:9]
	typedef logic [37:0] pc38_t;

	typedef logic [`BTB_IDX_W-1:0] fetch_idx_t;
	typedef logic [`BTB_LANE_W-1:0] fetch_lane_t;
	typedef logic [`BTB_WAY_W-1:0] btb_way_idx_t;
	typedef logic [`BTB_TAG_W-1:0] btb_tag_t;

	// ------------------------------
	// structs
	// ------------------------------

	// opaque to the btb, carried through unchanged
	typedef struct packed {
		logic [1:0] br_type;
		logic [13:0] target_low;
	} btb_info_t;

	// valid bit lives in the array next to this
	typedef struct packed {
		btb_tag_t tag;
		fetch_lane_t lane;
		btb_info_t info;
	} btb_entry_t;

	// fold upper pc bits and asid down to the tag width
	function automatic btb_tag_t btb_hash_tag(input pc38_t pc, input asid_t asid);
		btb_tag_t fold;
		fold = pc[18:9] ^ pc[28:19];
		fold = fold ^ btb_tag_t'(pc[37:29]);
		fold = fold ^ btb_tag_t'(asid);
		return fold;
	endfunction

endpackage

`default_nettype wire

//--- design/btb_tag_match.sv
`default_nettype none

`include "btb_config.svh"

module btb_tag_match (
	// array read data
	input btb_pkg::btb_entry_t [`BTB_WAYS-1:0] entries,
	input logic [`BTB_WAYS-1:0] valids,

	// response stage lookup
	input btb_pkg::pc38_t pc38,
	input btb_pkg::asid_t asid,
	input logic resp_valid,

	output logic hit,
	output btb_pkg::btb_way_idx_t hit_way,
	output btb_pkg::fetch_lane_t hit_lane,
	output logic double_hit,
	output btb_pkg::btb_info_t btb_info
);

	import btb_pkg::*;

	btb_tag_t pc_tag;
	fetch_lane_t pc_lane;
	logic [`BTB_WAYS-1:0] way_hit;

	// ------------------------------
	// per-way compare
	// ------------------------------

	always_comb begin
		pc_tag = btb_hash_tag(pc38, asid);
		pc_lane = pc38[`BTB_LANE_W-1:0];
	end

	// branch must sit at or after the fetch lane
	always_comb begin
		for (int w = 0; w < `BTB_WAYS; w++) begin
			way_hit[w] = resp_valid && valids[w]
				&& (entries[w].tag == pc_tag)
				&& (entries[w].lane >= pc_lane);
		end
	end

	// ------------------------------
	// hit select
	// ------------------------------

	// lowest lane wins, lower way on a tie
	always_comb begin
		hit = 1'b0;
		hit_way = '0;
		hit_lane = '0;
		double_hit = 1'b0;
		btb_info = '0;
		for (int w = 0; w < `BTB_WAYS; w++) begin
			if (way_hit[w]) begin
				if (hit) begin
					double_hit = 1'b1;
				end
				if (!hit || (entries[w].lane < hit_lane)) begin
					hit = 1'b1;
					hit_way = btb_way_idx_t'(w);
					hit_lane = entries[w].lane;
					btb_info = entries[w].info;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- design/btb_wrapper.sv
`default_nettype none

module btb_wrapper (
	input logic CLK,
	input logic nRST,

	// arch state
	input btb_pkg::asid_t next_arch_asid,

	// read req stage
	input logic next_read_req_valid,
	input btb_pkg::fetch_idx_t next_read_req_fetch_index,

	// read resp stage
	input btb_pkg::pc38_t next_read_resp_pc38,

	output logic last_read_resp_hit,
	output btb_pkg::btb_way_idx_t last_read_resp_hit_way,
	output btb_pkg::fetch_lane_t last_read_resp_hit_lane,
	output logic last_read_resp_double_hit,
	output btb_pkg::btb_info_t last_read_resp_btb_info,

	// update
	input logic next_update_valid,
	input btb_pkg::pc38_t next_update_pc38,
	input btb_pkg::btb_info_t next_update_btb_info,
	input logic next_update_hit,
	input btb_pkg::btb_way_idx_t next_update_hit_way
);

	import btb_pkg::*;

	// ------------------------------
	// core side signals
	// ------------------------------

	asid_t arch_asid;
	logic read_req_valid;
	fetch_idx_t read_req_fetch_index;
	pc38_t read_resp_pc38;

	logic read_resp_hit;
	btb_way_idx_t read_resp_hit_way;
	fetch_lane_t read_resp_hit_lane;
	logic read_resp_double_hit;
	btb_info_t read_resp_btb_info;

	logic update_valid;
	pc38_t update_pc38;
	btb_info_t update_btb_info;
	logic update_hit;
	btb_way_idx_t update_hit_way;

	btb core (.*);

	// ------------------------------
	// port registers
	// ------------------------------

	always_ff @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			arch_asid <= '0;
			read_req_valid <= 1'b0;
			read_req_fetch_index <= '0;
			read_resp_pc38 <= '0;
			last_read_resp_hit <= 1'b0;
			last_read_resp_hit_way <= '0;
			last_read_resp_hit_lane <= '0;
			last_read_resp_double_hit <= 1'b0;
			last_read_resp_btb_info <= '0;
			update_valid <= 1'b0;
			update_pc38 <= '0;
			update_btb_info <= '0;
			update_hit <= 1'b0;
			update_hit_way <= '0;
		end else begin
			// inputs toward the core
			arch_asid <= next_arch_asid;
			read_req_valid <= next_read_req_valid;
			read_req_fetch_index <= next_read_req_fetch_index;
			read_resp_pc38 <= next_read_resp_pc38;
			update_valid <= next_update_valid;
			update_pc38 <= next_update_pc38;
			update_btb_info <= next_update_btb_info;
			update_hit <= next_update_hit;
			update_hit_way <= next_update_hit_way;
			// response out of the core
			last_read_resp_hit <= read_resp_hit;
			last_read_resp_hit_way <= read_resp_hit_way;
			last_read_resp_hit_lane <= read_resp_hit_lane;
			last_read_resp_double_hit <= read_resp_double_hit;
			last_read_resp_btb_info <= read_resp_btb_info;
		end
	end

endmodule

`default_nettype wire

//--- flist.f
+incdir+design
design/btb_pkg.sv
design/btb_array.sv
design/btb_tag_match.sv
design/btb_lru.sv
design/btb.sv
design/btb_wrapper.sv
test/btb_clock_gen.sv
test/btb_tb.sv

//--- test/btb_clock_gen.sv
`default_nettype none

module btb_clock_gen (
	output logic CLK
);

	timeunit 1ns;
	timeprecision 100ps;

	// 100 ns period
	initial begin
		CLK = 1'b0;
		forever begin
			#50 CLK = ~CLK;
		end
	end

endmodule

`default_nettype wire

//--- test/btb_tb.sv
`default_nettype none

`include "btb_config.svh"

module btb_tb;

	timeunit 1ns;
	timeprecision 100ps;

	import btb_pkg::*;

	// one cycle of stimulus at the wrapper ports
	typedef struct packed {
		logic req_valid;
		pc38_t req_pc;
		asid_t asid;
		logic upd_valid;
		pc38_t upd_pc;
		btb_info_t upd_info;
		logic upd_hit;
		btb_way_idx_t upd_way;
	} stim_t;

	typedef struct packed {
		logic hit;
		btb_way_idx_t way;
		fetch_lane_t lane;
		logic double_hit;
		btb_info_t info;
	} resp_t;

	localparam resp_t MISS = '0;

	logic CLK;
	logic nRST;
	asid_t next_arch_asid;
	logic next_read_req_valid;
	fetch_idx_t next_read_req_fetch_index;
	pc38_t next_read_resp_pc38;
	logic last_read_resp_hit;
	btb_way_idx_t last_read_resp_hit_way;
	fetch_lane_t last_read_resp_hit_lane;
	logic last_read_resp_double_hit;
	btb_info_t last_read_resp_btb_info;
	logic next_update_valid;
	pc38_t next_update_pc38;
	btb_info_t next_update_btb_info;
	logic next_update_hit;
	btb_way_idx_t next_update_hit_way;

	resp_t actual;

	// reference model state
	btb_entry_t m_entry [`BTB_SETS][2];
	logic [1:0] m_valid [`BTB_SETS];
	btb_way_idx_t m_lru [`BTB_SETS];
	btb_entry_t snap_entry [2];
	logic [1:0] snap_valid;
	logic prev_req;
	fetch_idx_t prev_idx;
	pc38_t prev_pc;
	resp_t exp_q [$];
	logic req_q [$];

	logic [31:0] rng;
	asid_t cur_asid;
	asid_t asid_a;
	asid_t asid_b;
	string test_name;

	btb_clock_gen clock_gen (.CLK(CLK));

	btb_wrapper dut (.*);

	assign actual = {last_read_resp_hit, last_read_resp_hit_way, last_read_resp_hit_lane,
		last_read_resp_double_hit, last_read_resp_btb_info};

	// ------------------------------
	// helpers
	// ------------------------------

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] rand32();
		rng = xorshift(rng);
		return rng;
	endfunction

	function automatic pc38_t make_pc(input logic [28:0] upper, input fetch_idx_t set,
		input fetch_lane_t lane);
		return {upper, set, lane};
	endfunction

	// tag is pc[18:9] ^ pc[28:19] ^ pc[37:29] ^ asid
	function automatic btb_tag_t fold_tag(input pc38_t pc, input asid_t asid);
		return pc[18:9] ^ pc[28:19] ^ {1'b0, pc[37:29]} ^ {1'b0, asid};
	endfunction

	function automatic resp_t hit_resp(input btb_way_idx_t way, input fetch_lane_t lane,
		input logic dbl, input btb_info_t info);
		resp_t r;
		r.hit = 1'b1;
		r.way = way;
		r.lane = lane;
		r.double_hit = dbl;
		r.info = info;
		return r;
	endfunction

	function automatic resp_t predict(input pc38_t pc, input asid_t asid);
		resp_t r;
		logic h0;
		logic h1;
		btb_tag_t tag;
		tag = fold_tag(pc, asid);
		h0 = snap_valid[0] && snap_entry[0].tag == tag && snap_entry[0].lane >= pc[2:0];
		h1 = snap_valid[1] && snap_entry[1].tag == tag && snap_entry[1].lane >= pc[2:0];
		r = MISS;
		// way 1 only wins with a strictly lower lane
		if (h0 && !(h1 && snap_entry[1].lane < snap_entry[0].lane)) begin
			r = hit_resp(1'b0, snap_entry[0].lane, 1'b0, snap_entry[0].info);
		end else if (h1) begin
			r = hit_resp(1'b1, snap_entry[1].lane, 1'b0, snap_entry[1].info);
		end
		r.double_hit = h0 && h1;
		return r;
	endfunction

	function automatic stim_t idle_stim();
		stim_t s;
		s = '0;
		s.asid = cur_asid;
		return s;
	endfunction

	// the newest request has not reached the queue yet
	function automatic int in_flight();
		int n;
		n = prev_req ? 1 : 0;
		foreach (req_q[i]) begin
			if (req_q[i]) begin
				n++;
			end
		end
		return n;
	endfunction

	task automatic stop_run();
		$display("SIMULATION FAILED");
		$fatal(1, "testbench stopped");
	endtask

	task automatic check(input string name, input resp_t expected, input resp_t got);
		if (got !== expected) begin
			$display("FAILED %s expected %h actual %h", name, expected, got);
			stop_run();
		end
	endtask

	// ------------------------------
	// one clock of stimulus and model
	// ------------------------------

	task automatic step(input stim_t s);
		resp_t r;
		fetch_idx_t ri;
		fetch_idx_t ui;
		btb_way_idx_t ww;
		@(posedge CLK);
		next_arch_asid <= s.asid;
		next_read_req_valid <= s.req_valid;
		next_read_req_fetch_index <= s.req_pc[8:3];
		next_read_resp_pc38 <= prev_pc;
		next_update_valid <= s.upd_valid;
		next_update_pc38 <= s.upd_pc;
		next_update_btb_info <= s.upd_info;
		next_update_hit <= s.upd_hit;
		next_update_hit_way <= s.upd_way;
		// previous request is looked up with this cycle's pc and asid
		r = MISS;
		if (prev_req) begin
			r = predict(prev_pc, s.asid);
		end
		exp_q.push_back(r);
		req_q.push_back(prev_req);
		ri = s.req_pc[8:3];
		ui = s.upd_pc[8:3];
		ww = s.upd_hit ? s.upd_way : m_lru[ui];
		// read and write share an edge so the read gets old data
		if (s.req_valid) begin
			snap_entry[0] = m_entry[ri][0];
			snap_entry[1] = m_entry[ri][1];
			snap_valid = m_valid[ri];
		end
		if (s.upd_valid) begin
			m_entry[ui][ww] = '{fold_tag(s.upd_pc, s.asid), s.upd_pc[2:0], s.upd_info};
			m_valid[ui][ww] = 1'b1;
		end
		if (r.hit) begin
			m_lru[prev_idx] = ~r.way;
		end
		// fill beats a read hit on the same set
		if (s.upd_valid) begin
			m_lru[ui] = ~ww;
		end
		prev_req = s.req_valid;
		prev_idx = ri;
		prev_pc = s.req_pc;
		@(negedge CLK);
		if (exp_q.size() > 2) begin
			void'(req_q.pop_front());
			check(test_name, exp_q.pop_front(), actual);
		end
	endtask

	task automatic update(input pc38_t pc, input btb_info_t info);
		stim_t s;
		s = idle_stim();
		s.upd_valid = 1'b1;
		s.upd_pc = pc;
		s.upd_info = info;
		step(s);
	endtask

	// request, then pc, then result two edges later
	task automatic probe(input pc38_t pc, input resp_t expected);
		stim_t s;
		s = idle_stim();
		s.req_valid = 1'b1;
		s.req_pc = pc;
		step(s);
		repeat (3) step(idle_stim());
		check({test_name, " probe"}, expected, actual);
	endtask

	// ------------------------------
	// stimulus
	// ------------------------------

	initial begin
		nRST <= 1'b0;
		repeat (16) @(posedge CLK);
		nRST <= 1'b1;
	end

	initial begin
		stim_t s;
		logic [31:0] r;
		logic [28:0] base;
		btb_info_t info [4];
		int waited;
		next_arch_asid <= '0;
		next_read_req_valid <= 1'b0;
		next_read_req_fetch_index <= '0;
		next_read_resp_pc38 <= '0;
		next_update_valid <= 1'b0;
		next_update_pc38 <= '0;
		next_update_btb_info <= '0;
		next_update_hit <= 1'b0;
		next_update_hit_way <= '0;
		for (int i = 0; i < `BTB_SETS; i++) begin
			m_entry[i][0] = '0;
			m_entry[i][1] = '0;
			m_valid[i] = '0;
			m_lru[i] = '0;
		end
		snap_entry[0] = '0;
		snap_entry[1] = '0;
		snap_valid = '0;
		prev_req = 1'b0;
		prev_idx = '0;
		prev_pc = '0;
		// outputs are idle for the first two checks
		exp_q.push_back(MISS);
		exp_q.push_back(MISS);
		req_q.push_back(1'b0);
		req_q.push_back(1'b0);
		rng = 32'hf122c068;
		r = rand32();
		base = r[28:0];
		r = rand32();
		asid_a = r[8:0];
		asid_b = asid_a ^ 9'h001;
		cur_asid = asid_a;
		for (int i = 0; i < 4; i++) begin
			r = rand32();
			info[i] = r[15:0];
		end

		test_name = "reset";
		waited = 0;
		while (nRST !== 1'b1) begin
			@(posedge CLK);
			waited++;
			if (waited > 32) begin
				$display("reset was never released");
				stop_run();
			end
		end

		test_name = "empty after reset";
		for (int i = 0; i < 6; i++) begin
			r = rand32();
			probe(make_pc(r[28:0], r[31:26], r[2:0]), MISS);
		end

		test_name = "update then lookup";
		update(make_pc(base, 6'd10, 3'd3), info[0]);
		probe(make_pc(base, 6'd10, 3'd3), hit_resp(1'b0, 3'd3, 1'b0, info[0]));
		probe(make_pc(base, 6'd10, 3'd1), hit_resp(1'b0, 3'd3, 1'b0, info[0]));
		probe(make_pc(base, 6'd10, 3'd5), MISS);

		test_name = "double hit";
		update(make_pc(base, 6'd20, 3'd6), info[1]);
		update(make_pc(base, 6'd20, 3'd2), info[2]);
		probe(make_pc(base, 6'd20, 3'd0), hit_resp(1'b1, 3'd2, 1'b1, info[2]));

		test_name = "asid change";
		update(make_pc(base, 6'd30, 3'd4), info[3]);
		cur_asid = asid_b;
		probe(make_pc(base, 6'd30, 3'd4), MISS);
		cur_asid = asid_a;
		probe(make_pc(base, 6'd30, 3'd4), hit_resp(1'b0, 3'd4, 1'b0, info[3]));

		// fills go to way 0 then way 1 and the hit on way 0 leaves way 1 as victim
		test_name = "lru eviction";
		update(make_pc(base, 6'd40, 3'd0), info[0]);
		update(make_pc(base ^ 29'd1, 6'd40, 3'd0), info[1]);
		probe(make_pc(base, 6'd40, 3'd0), hit_resp(1'b0, 3'd0, 1'b0, info[0]));
		update(make_pc(base ^ 29'd2, 6'd40, 3'd0), info[2]);
		probe(make_pc(base, 6'd40, 3'd0), hit_resp(1'b0, 3'd0, 1'b0, info[0]));
		probe(make_pc(base ^ 29'd1, 6'd40, 3'd0), MISS);
		probe(make_pc(base ^ 29'd2, 6'd40, 3'd0), hit_resp(1'b1, 3'd0, 1'b0, info[2]));

		// few sets and few tags so hits and evictions are common
		test_name = "random traffic";
		for (int i = 0; i < 2000; i++) begin
			r = rand32();
			if (r[2:0] == 3'b000) begin
				cur_asid = r[3] ? asid_b : asid_a;
			end
			s = idle_stim();
			s.req_valid = r[5:4] != 2'b00;
			s.req_pc = make_pc(base ^ {27'd0, r[7:6]}, {4'd0, r[9:8]}, r[12:10]);
			s.upd_valid = r[14:13] == 2'b00;
			s.upd_pc = make_pc(base ^ {27'd0, r[16:15]}, {4'd0, r[18:17]}, r[21:19]);
			s.upd_hit = r[23:22] == 2'b00;
			s.upd_way = r[24];
			r = rand32();
			s.upd_info = r[15:0];
			step(s);
		end

		test_name = "drain";
		waited = 0;
		while (in_flight() > 0) begin
			step(idle_stim());
			waited++;
			if (waited > 8) begin
				$display("requests still outstanding after the drain");
				stop_run();
			end
		end

		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

`default_nettype wire
